//--- all.f
hw/dcache_pkg.sv
hw/tag_if.sv
hw/data_if.sv
hw/burst_counter.sv
hw/lru_policy.sv
hw/tag_store.sv
hw/data_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_tb_assert.sv
verif/dcache_tb.sv

//--- hw/burst_counter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_counter
  import dcache_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    clear,
  input  logic    step,
  output offset_t word,
  output logic    last
);
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      word <= '0;
    else if (clear)
      word <= '0;
    else if (step)
      word <= word + 1'b1;  // one per word moved
  end

  assign last = (word == offset_t'(LINE_WORDS - 1));
endmodule

`default_nettype wire

//--- hw/data_if.sv
`timescale 1ns/1ps
`default_nettype none

interface data_if
  import dcache_pkg::*;
();
  index_t  index;
  way_t    way;
  offset_t offset;
  word_t   wr_data;
  strobe_t strb;
  logic    wr_en;

  // word at index/way/offset, no register
  word_t   rd_data;

  modport ctrl (output index, way, offset, wr_data, strb, wr_en,
                input  rd_data);

  modport store (input  index, way, offset, wr_data, strb, wr_en,
                 output rd_data);
endinterface

`default_nettype wire

//--- hw/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store
  import dcache_pkg::*;
(
  input logic   clk,
  data_if.store data
);
  word_t mem [NUM_WAYS][NUM_SETS][LINE_WORDS];

  ////////////////////
  // byte-enabled word write
  always_ff @(posedge clk)
  begin
    if (data.wr_en)
    begin
      for (int b = 0; b < $bits(strobe_t); b++)
      begin
        if (data.strb[b])
          mem[data.way][data.index][data.offset][8*b +: 8] <= data.wr_data[8*b +: 8];
      end
    end
  end

  // async read
  assign data.rd_data = mem[data.way][data.index][data.offset];
endmodule

`default_nettype wire

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    req,
  input  logic    we,
  input  addr_t   addr,
  input  word_t   wdata,
  input  strobe_t wstrb,
  output logic    done,
  output word_t   rdata,
  output logic    wr_en,
  output addr_t   wr_addr,
  output word_t   wr_data,
  input  logic    wr_ready,
  output logic    rd_en,
  output addr_t   rd_addr,
  input  word_t   rd_data,
  input  logic    rd_valid,
  tag_if.ctrl     tags,
  data_if.ctrl    data,
  output logic    cnt_clear,
  output logic    cnt_step,
  input  offset_t cnt_word,
  input  logic    cnt_last
);
  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        req_we;
  addr_t       req_addr;
  word_t       req_wdata;
  strobe_t     req_strb;
  tag_t        req_tag;
  index_t      req_index;
  offset_t     req_offset;
  word_t       merged;

  assign req_tag    = req_addr[LINE_SHIFT+INDEX_BITS +: TAG_BITS];
  assign req_index  = req_addr[LINE_SHIFT +: INDEX_BITS];
  assign req_offset = req_addr[2 +: OFFSET_BITS];

  ////////////////////
  // request capture
  always_ff @(posedge clk)
  begin
    if (state == IDLE && req)
    begin
      req_we    <= we;
      req_addr  <= addr;
      req_wdata <= wdata;
      req_strb  <= wstrb;
    end
  end

  ////////////////////
  // miss FSM
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    cnt_clear  = 1'b0;
    case (state)
      IDLE:
        if (req)
          state_next = LOOKUP;
      LOOKUP:
        if (tags.hit)
          state_next = IDLE;
        else
        begin
          cnt_clear  = 1'b1;
          state_next = tags.victim_dirty ? EVICT : REFILL;
        end
      EVICT:
        if (cnt_step && cnt_last)
        begin
          cnt_clear  = 1'b1;  // refill restarts at word 0
          state_next = REFILL;
        end
      default:
        if (cnt_step && cnt_last)
          state_next = LOOKUP;  // retry, hits now
    endcase
  end

  // memory ports
  assign wr_en    = (state == EVICT);
  assign rd_en    = (state == REFILL);
  assign wr_addr  = {tags.victim_tag, req_index, {LINE_SHIFT{1'b0}}};
  assign rd_addr  = {req_tag, req_index, {LINE_SHIFT{1'b0}}};
  assign wr_data  = data.rd_data;
  assign cnt_step = (wr_en && wr_ready) || (rd_en && rd_valid);

  // tag store control
  assign tags.index      = req_index;
  assign tags.tag        = req_tag;
  assign tags.touch      = (state == LOOKUP) && tags.hit;
  assign tags.mark_dirty = tags.touch && req_we;
  assign tags.fill       = rd_en && rd_valid && cnt_last;

  // data store port, hit way on lookup, victim way during bursts
  assign data.index   = req_index;
  assign data.way     = (state == LOOKUP) ? tags.hit_way : tags.victim_way;
  assign data.offset  = (state == LOOKUP) ? req_offset : cnt_word;
  assign data.wr_data = rd_en ? rd_data : req_wdata;
  assign data.strb    = rd_en ? '1 : req_strb;
  assign data.wr_en   = tags.mark_dirty || (rd_en && rd_valid);

  always_comb
  begin
    for (int b = 0; b < $bits(strobe_t); b++)
      merged[8*b +: 8] = req_strb[b] ? req_wdata[8*b +: 8] : data.rd_data[8*b +: 8];
  end

  assign done  = tags.touch;
  assign rdata = req_we ? merged : data.rd_data;
endmodule

`default_nettype wire

//--- hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  ////////////////////
  // geometry
  localparam int NUM_WAYS    = 4;
  localparam int NUM_SETS    = 16;
  localparam int LINE_WORDS  = 16;
  localparam int TAG_BITS    = 22;
  localparam int INDEX_BITS  = 4;
  localparam int OFFSET_BITS = 4;
  localparam int AGE_BITS    = 2;
  localparam int LINE_SHIFT  = 6;  // byte offset width of a line

  ////////////////////
  // address fields and payloads
  typedef logic [31:0]              word_t;
  typedef logic [31:0]              addr_t;
  typedef logic [TAG_BITS-1:0]      tag_t;     // addr[31:10]
  typedef logic [INDEX_BITS-1:0]    index_t;   // addr[9:6]
  typedef logic [OFFSET_BITS-1:0]   offset_t;  // addr[5:2]
  typedef logic [$clog2(NUM_WAYS)-1:0] way_t;
  typedef logic [AGE_BITS-1:0]      age_t;
  typedef logic [3:0]               strobe_t;  // bit n -> byte n

  typedef enum logic [1:0] {IDLE, LOOKUP, EVICT, REFILL} ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
  import dcache_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  // cpu side
  input  logic    req,
  input  logic    we,
  input  addr_t   addr,
  input  word_t   wdata,
  input  strobe_t wstrb,
  output logic    done,
  output word_t   rdata,
  // write-back channel
  output logic    wr_en,
  output addr_t   wr_addr,
  output word_t   wr_data,
  input  logic    wr_ready,
  // refill channel
  output logic    rd_en,
  output addr_t   rd_addr,
  input  word_t   rd_data,
  input  logic    rd_valid
);
  logic    cnt_clear;
  logic    cnt_step;
  offset_t cnt_word;
  logic    cnt_last;

  tag_if  tags ();
  data_if data ();

  dcache_ctrl ctrl_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .we       (we),
    .addr     (addr),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .done     (done),
    .rdata    (rdata),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_ready (wr_ready),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .tags     (tags.ctrl),
    .data     (data.ctrl),
    .cnt_clear(cnt_clear),
    .cnt_step (cnt_step),
    .cnt_word (cnt_word),
    .cnt_last (cnt_last)
  );

  burst_counter counter_i (
    .clk  (clk),
    .rst  (rst),
    .clear(cnt_clear),
    .step (cnt_step),
    .word (cnt_word),
    .last (cnt_last)
  );

  // lru ages live inside the tag store
  tag_store tag_store_i (
    .clk (clk),
    .rst (rst),
    .tags(tags.store)
  );

  data_store data_store_i (
    .clk (clk),
    .data(data.store)
  );
endmodule

`default_nettype wire

//--- hw/lru_policy.sv
`timescale 1ns/1ps
`default_nettype none

module lru_policy
  import dcache_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  index_t index,
  input  logic   touch,
  input  way_t   touch_way,
  output way_t   oldest_way
);
  age_t ages [NUM_SETS][NUM_WAYS];
  age_t touch_age;

  assign touch_age = ages[index][touch_way];

  ////////////////////
  // age update
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < NUM_SETS; s++)
        for (int w = 0; w < NUM_WAYS; w++)
          ages[s][w] <= '0;
    end
    else if (touch)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        if (way_t'(w) == touch_way)
          ages[index][w] <= '0;
        else if (ages[index][w] <= touch_age && ages[index][w] != '1)
          ages[index][w] <= ages[index][w] + 1'b1;  // saturates at max
      end
    end
  end

  // highest age, ties to the lower way
  always_comb
  begin
    oldest_way = '0;
    for (int w = 1; w < NUM_WAYS; w++)
    begin
      if (ages[index][w] > ages[index][oldest_way])
        oldest_way = way_t'(w);
    end
  end
endmodule

`default_nettype wire

//--- hw/tag_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tag_if
  import dcache_pkg::*;
();
  index_t index;
  tag_t   tag;
  logic   touch;       // hit, ages the ways
  logic   fill;        // new line into victim way
  logic   mark_dirty;

  logic   hit;
  way_t   hit_way;
  way_t   victim_way;
  tag_t   victim_tag;
  logic   victim_dirty;

  modport ctrl (output index, tag, touch, fill, mark_dirty,
                input  hit, hit_way, victim_way, victim_tag, victim_dirty);

  modport store (input  index, tag, touch, fill, mark_dirty,
                 output hit, hit_way, victim_way, victim_tag, victim_dirty);
endinterface

`default_nettype wire

//--- hw/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store
  import dcache_pkg::*;
(
  input logic  clk,
  input logic  rst,
  tag_if.store tags
);
  tag_t                tag_mem [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] valid [NUM_SETS];
  logic [NUM_WAYS-1:0] dirty [NUM_SETS];
  logic [NUM_WAYS-1:0] match;
  logic                has_free;
  way_t                free_way;
  way_t                oldest_way;

  lru_policy lru_i (
    .clk       (clk),
    .rst       (rst),
    .index     (tags.index),
    .touch     (tags.touch),
    .touch_way (tags.hit_way),
    .oldest_way(oldest_way)
  );

  ////////////////////
  // lookup and victim
  always_comb
  begin
    match        = '0;
    tags.hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      match[w] = valid[tags.index][w] && (tag_mem[tags.index][w] == tags.tag);
      if (match[w])
        tags.hit_way = way_t'(w);
    end
  end

  assign tags.hit = |match;

  always_comb
  begin
    has_free = 1'b0;
    free_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--)  // lowest invalid wins
    begin
      if (!valid[tags.index][w])
      begin
        has_free = 1'b1;
        free_way = way_t'(w);
      end
    end
  end

  assign tags.victim_way   = has_free ? free_way : oldest_way;
  assign tags.victim_tag   = tag_mem[tags.index][tags.victim_way];
  assign tags.victim_dirty = valid[tags.index][tags.victim_way] &&
                             dirty[tags.index][tags.victim_way];

  always_ff @(posedge clk)
  begin
    if (tags.fill)
      tag_mem[tags.index][tags.victim_way] <= tags.tag;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < NUM_SETS; s++)
      begin
        valid[s] <= '0;
        dirty[s] <= '0;
      end
    end
    else if (tags.fill)
    begin
      valid[tags.index][tags.victim_way] <= 1'b1;
      dirty[tags.index][tags.victim_way] <= 1'b0;  // clean copy of memory
    end
    else if (tags.mark_dirty)
      dirty[tags.index][tags.hit_way] <= 1'b1;
  end
endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds and runs the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module dcache_tb -f all.f -o dcache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dcache_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

//--- verif/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
();
  localparam int    SEED        = 70153;
  localparam int    N_REQ       = 1 + 1 + 80 + 6 + 80 + 400;
  localparam int    MISS_CYCLES = 2 * LINE_WORDS * 16 + 8;  // zero runs of the lfsr stay under 16
  localparam int    MAX_CYCLES  = N_REQ * MISS_CYCLES;
  localparam word_t FILL_KEY    = 32'hC3A5_0F1E;

  logic    clk = 1'b0;
  logic    rst = 1'b1;
  logic    req = 1'b0;
  logic    we = 1'b0;
  addr_t   addr = '0;
  word_t   wdata = '0;
  strobe_t wstrb = '0;
  logic    done;
  word_t   rdata;
  logic    wr_en;
  addr_t   wr_addr;
  word_t   wr_data;
  logic    wr_ready = 1'b0;
  logic    rd_en;
  addr_t   rd_addr;
  word_t   rd_data = '0;
  logic    rd_valid = 1'b0;

  logic [15:0] stim_lfsr = SEED[15:0];
  logic [15:0] mem_lfsr = SEED[15:0];
  word_t       backing [logic [29:0]];
  word_t       golden [logic [29:0]];
  addr_t       wb_lines [$];
  int          wcnt = 0;
  offset_t     rcnt = '0;
  int          cycles = 0;
  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          test_start_err = 0;
  int          last_lat = 0;
  int          wb_count = 0;

  dcache_top dcache_top_i (.*);

  always #20 clk = ~clk;

  ////////////////////
  // helpers
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], stim_lfsr[15]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
    return r;
  endfunction

  function automatic word_t fill_word(input addr_t a);
    return {2'b00, a[31:2]} ^ FILL_KEY;
  endfunction

  function automatic word_t mem_word(input addr_t a);
    return backing.exists(a[31:2]) ? backing[a[31:2]] : fill_word(a);
  endfunction

  function automatic word_t gold_word(input addr_t a);
    return golden.exists(a[31:2]) ? golden[a[31:2]] : fill_word(a);
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t nw, input strobe_t s);
    word_t r;
    r = old;
    for (int b = 0; b < 4; b++)
      if (s[b])
        r[8*b +: 8] = nw[8*b +: 8];
    return r;
  endfunction

  function automatic addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
    return {t, i, o, 2'b00};
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_start_err)
      $display("test %0d %s: ok", tests, name);
    else
    begin
      failed_tests++;
      $display("test %0d %s: failed with %0d errors", tests, name, errors - test_start_err);
    end
    test_start_err = errors;
  endtask

  // one request, waits for done and checks rdata
  task automatic access(input logic w, input addr_t a, input word_t d, input strobe_t s);
    word_t exp;
    int    lat;
    exp = w ? merge_bytes(gold_word(a), d, s) : gold_word(a);
    @(negedge clk);
    req = 1'b1;
    we = w;
    addr = a;
    wdata = d;
    wstrb = s;
    @(negedge clk);
    req = 1'b0;
    lat = 1;
    while (!done)
    begin
      @(negedge clk);
      lat++;
    end
    last_lat = lat;
    check_eq(rdata, exp, $sformatf("%s at %h", w ? "write" : "read", a));
    if (w)
      golden[a[31:2]] = exp;
  endtask

  task automatic check_written_back();
    addr_t line;
    while (wb_lines.size() > 0)
    begin
      line = wb_lines.pop_front();
      wb_count++;
      for (int w = 0; w < LINE_WORDS; w++)
        check_eq(mem_word(line + addr_t'(4 * w)), gold_word(line + addr_t'(4 * w)),
                 $sformatf("write-back line %h word %0d", line, w));
    end
  endtask

  ////////////////////
  // memory model
  always @(negedge clk)
  begin
    wr_ready = mem_lfsr[15];
    mem_lfsr = lfsr_next(mem_lfsr);
    rd_valid = rd_en && mem_lfsr[15];
    mem_lfsr = lfsr_next(mem_lfsr);
    if (wr_en && wr_ready)  // taken at the next rising edge
    begin
      backing[wr_addr[31:2] + 30'(wcnt)] = wr_data;
      wcnt++;
      if (wcnt == LINE_WORDS)
      begin
        wb_lines.push_back(wr_addr);
        wcnt = 0;
      end
    end
    if (rd_valid)
    begin
      rd_data = mem_word({rd_addr[31:6], rcnt, 2'b00});
      rcnt = rcnt + 1'b1;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES)
    begin
      $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////
  // tests
  initial
  begin
    addr_t a;
    addr_t q3 [$];
    addr_t lines [5];
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_eq(32'(done), 0, "done after reset");
    check_eq(32'(wr_en), 0, "wr_en after reset");
    check_eq(32'(rd_en), 0, "rd_en after reset");
    a = make_addr(22'h3, 4'd0, 4'd5);
    access(1'b0, a, '0, '0);
    end_test("reset state");

    access(1'b0, a, '0, '0);
    check_eq(32'(last_lat), 1, "hit latency");
    end_test("hit latency");

    for (int i = 0; i < 40; i++)  // sets 0 to 7, eight tags
    begin
      a = make_addr(tag_t'(next_bits(3)), index_t'(next_bits(3)), offset_t'(next_bits(4)));
      q3.push_back(a);
      access(1'b1, a, next_bits(32), strobe_t'(next_bits(4)));
    end
    foreach (q3[i])
      access(1'b0, q3[i], '0, '0);
    end_test("byte writes");

    for (int k = 0; k < 5; k++)
      lines[k] = make_addr(tag_t'(32'h100 + k), 4'd15, 4'd0);
    for (int k = 0; k < 4; k++)
      access(1'b1, lines[k], next_bits(32), 4'hF);
    access(1'b0, lines[0], '0, '0);
    wb_lines.delete();
    access(1'b0, lines[4], '0, '0);
    check_eq(32'(wb_lines.size()), 1, "write-back count on E");
    if (wb_lines.size() > 0)
      check_eq(wb_lines[0], lines[1], "LRU victim line");
    end_test("LRU victim");

    wb_lines.delete();
    for (int i = 0; i < 80; i++)  // 6 tags over sets 12 and 13
    begin
      a = make_addr(tag_t'(32'h200 + next_bits(3) % 6), index_t'(12 + next_bits(1)),
                    offset_t'(next_bits(4)));
      access(1'(next_bits(1)), a, next_bits(32), strobe_t'(next_bits(4)));
      check_written_back();
    end
    check_eq(32'(wb_count > 0), 1, "write-backs seen");
    end_test("write-back content");

    for (int i = 0; i < 400; i++)
    begin
      a = make_addr(tag_t'(next_bits(4)), index_t'(next_bits(4)), offset_t'(next_bits(4)));
      access(1'(next_bits(1)), a, next_bits(32), strobe_t'(next_bits(4)));
    end
    check_eq(32'(dcache_top_i.assert_i.fails), 0, "protocol assertion failures");
    end_test("random mixed run");

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end
endmodule

`default_nettype wire

//--- verif/dcache_tb_assert.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb_assert
  import dcache_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input logic  done,
  input logic  wr_en,
  input logic  rd_en,
  input addr_t wr_addr,
  input addr_t rd_addr
);
  int fails = 0;

  ////////////////////
  // cpu handshake
  done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
  else
  begin
    $error("done high in two cycles in a row");
    fails++;
  end

  ////////////////////
  // memory channels
  one_channel: assert property (@(posedge clk) disable iff (rst) !(wr_en && rd_en))
  else
  begin
    $error("wr_en and rd_en high together");
    fails++;
  end

  quiet_on_done: assert property (@(posedge clk) disable iff (rst) done |-> !wr_en && !rd_en)
  else
  begin
    $error("memory channel busy in a done cycle");
    fails++;
  end

  line_aligned: assert property (@(posedge clk) disable iff (rst)
                                 wr_addr[5:0] == '0 && rd_addr[5:0] == '0)
  else
  begin
    $error("burst address not line aligned");
    fails++;
  end
endmodule

bind dcache_top dcache_tb_assert assert_i (
  .clk    (clk),
  .rst    (rst),
  .done   (done),
  .wr_en  (wr_en),
  .rd_en  (rd_en),
  .wr_addr(wr_addr),
  .rd_addr(rd_addr)
);

`default_nettype wire
